//--- Makefile
# Verilator build and run of the rename stage testbench

VERILATOR ?= verilator
TOP       ?= tb_rename
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= No errors
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)
	$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "^$(PASS_MSG)$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- common/rn_pkg.sv
/*
   Shared register widths and the rename request, response and commit structs
*/
package rn_pkg;

   // Logical and physical register number widths
   localparam int LRF_AW = 5;
   localparam int PRF_AW = 6;

   localparam int N_LRF = 1 << LRF_AW;            // Architectural registers
   localparam int N_PRF = 1 << PRF_AW;            // Physical registers

   // Physical registers that are not mapped after reset start out free
   localparam int FL_DEPTH = N_PRF - N_LRF;

   // One instruction entering rename
   typedef struct packed {
      logic              valid;
      logic              lrd_we;                  // Instruction writes a destination
      logic [LRF_AW-1:0] lrs1;
      logic [LRF_AW-1:0] lrs2;
      logic [LRF_AW-1:0] lrd;
   } rn_req_t;

   // One renamed instruction, sent on to the scheduler
   typedef struct packed {
      logic              valid;
      logic [PRF_AW-1:0] prs1;
      logic [PRF_AW-1:0] prs2;
      logic [PRF_AW-1:0] prd;                     // Newly allocated destination
      logic [PRF_AW-1:0] pfree;                   // Old mapping, freed when this commits
   } rn_rsp_t;

   // One instruction retiring from the ROB
   typedef struct packed {
      logic              we;
      logic [LRF_AW-1:0] lrd;
      logic [PRF_AW-1:0] prd;                     // Becomes the architectural mapping
      logic [PRF_AW-1:0] pfree;                   // Goes back to the free list
   } rn_commit_t;

   localparam int RN_REQ_W    = $bits(rn_req_t);
   localparam int RN_RSP_W    = $bits(rn_rsp_t);
   localparam int RN_COMMIT_W = $bits(rn_commit_t);

endpackage

//--- compile.f
common/rn_pkg.sv
rename/rn_rat.sv
rename/rn_freelist.sv
rename/rn_rename.sv
test/tb_rename.sv

//--- rename/rn_freelist.sv
/*
   Circular free list of physical registers with speculative and committed heads
*/
module rn_freelist
   import rn_pkg::*;
#(
   parameter int ISSUE_WIDTH  = 2,
   parameter int COMMIT_WIDTH = 2
)
(
   input  logic                   clk,
   input  logic                   rst_n,
   input  logic [ISSUE_WIDTH-1:0] alloc,
   input  logic                   rollback,
   input  rn_commit_t             commit [COMMIT_WIDTH],
   output logic [PRF_AW-1:0]      fl_prd [ISSUE_WIDTH],
   output logic                   rename_ready
);

   localparam int IDX_W = $clog2(FL_DEPTH);
   localparam int PTR_W = IDX_W + 1;              // Extra bit tells full from empty

   logic [PRF_AW-1:0] fl_mem [FL_DEPTH];
   logic [PTR_W-1:0]  spec_head;                  // Next entry handed to rename
   logic [PTR_W-1:0]  cmt_head;                   // Oldest entry not yet committed
   logic [PTR_W-1:0]  tail;                       // Where freed registers are pushed
   logic [PTR_W-1:0]  fl_count;
   logic [PTR_W-1:0]  alloc_cnt;
   logic [PTR_W-1:0]  free_cnt;
   logic [PTR_W-1:0]  rd_ptr [ISSUE_WIDTH];
   logic [PTR_W-1:0]  wr_ptr [COMMIT_WIDTH];

   // Requesting slots take consecutive entries, so each slot's offset is the
   // number of requesting slots before it
   always_comb
   begin
      alloc_cnt = '0;
      for (int i = 0; i < ISSUE_WIDTH; i++)
      begin
         rd_ptr[i] = spec_head + alloc_cnt;
         alloc_cnt = alloc_cnt + PTR_W'(alloc[i]);
      end
   end

   always_comb
   begin
      free_cnt = '0;
      for (int k = 0; k < COMMIT_WIDTH; k++)
      begin
         wr_ptr[k] = tail + free_cnt;
         free_cnt  = free_cnt + PTR_W'(commit[k].we);
      end
   end

   always_comb
   begin
      for (int i = 0; i < ISSUE_WIDTH; i++)
         fl_prd[i] = fl_mem[rd_ptr[i][IDX_W-1:0]];
   end

   assign fl_count     = tail - spec_head;
   assign rename_ready = fl_count >= PTR_W'(ISSUE_WIDTH);   // Room for a full group

   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         spec_head <= '0;
         cmt_head  <= '0;
         tail      <= PTR_W'(FL_DEPTH);
      end
      else
      begin
         cmt_head <= cmt_head + free_cnt;
         tail     <= tail + free_cnt;
         if (rollback)
            spec_head <= cmt_head + free_cnt;     // Uncommitted allocations return
         else
            spec_head <= spec_head + alloc_cnt;
      end
   end

   // Registers N_LRF and up are the ones left unmapped at reset
   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         for (int i = 0; i < FL_DEPTH; i++)
            fl_mem[i] <= PRF_AW'(N_LRF + i);
      end
      else
      begin
         for (int k = 0; k < COMMIT_WIDTH; k++)
         begin
            if (commit[k].we)
               fl_mem[wr_ptr[k][IDX_W-1:0]] <= commit[k].pfree;
         end
      end
   end

   a_alloc_when_ready : assert property (
      @(posedge clk) disable iff (!rst_n) (|alloc) |-> rename_ready
   );

   a_count_in_range : assert property (
      @(posedge clk) disable iff (!rst_n) fl_count <= PTR_W'(FL_DEPTH)
   );

endmodule

//--- rename/rn_rat.sv
/*
   Speculative and architectural register alias tables with in-group
   RAW/WAW bypass and rollback restore
*/
module rn_rat
   import rn_pkg::*;
#(
   parameter int ISSUE_WIDTH  = 2,
   parameter int COMMIT_WIDTH = 2
)
(
   input  logic              clk,
   input  logic              rst_n,
   input  rn_req_t           req [ISSUE_WIDTH],
   input  logic [PRF_AW-1:0] fl_prd [ISSUE_WIDTH],
   input  logic              rollback,
   input  rn_commit_t        commit [COMMIT_WIDTH],
   output logic [PRF_AW-1:0] prs1 [ISSUE_WIDTH],
   output logic [PRF_AW-1:0] prs2 [ISSUE_WIDTH],
   output logic [PRF_AW-1:0] pfree [ISSUE_WIDTH]
);

   logic [PRF_AW-1:0]      rat [N_LRF];           // Speculative mapping
   logic [PRF_AW-1:0]      arat [N_LRF];          // Committed mapping
   logic [PRF_AW-1:0]      arat_nxt [N_LRF];      // Committed mapping after this cycle
   logic [ISSUE_WIDTH-1:0] slot_we;               // Slot allocates a destination
   logic                   commit_dup;            // Two commits name one lrd

   always_comb
   begin
      for (int i = 0; i < ISSUE_WIDTH; i++)
         slot_we[i] = req[i].valid & req[i].lrd_we;
   end

   // Table lookup, then overridden by earlier writers in the same group.
   // Walking j upward lets the nearest earlier slot win.
   always_comb
   begin
      for (int i = 0; i < ISSUE_WIDTH; i++)
      begin
         prs1[i]  = rat[req[i].lrs1];
         prs2[i]  = rat[req[i].lrs2];
         pfree[i] = rat[req[i].lrd];
         for (int j = 0; j < i; j++)
         begin
            if (slot_we[j] && req[j].lrd == req[i].lrs1)
               prs1[i] = fl_prd[j];               // RAW on source 1
            if (slot_we[j] && req[j].lrd == req[i].lrs2)
               prs2[i] = fl_prd[j];               // RAW on source 2
            if (slot_we[j] && req[j].lrd == req[i].lrd)
               pfree[i] = fl_prd[j];              // WAW frees the earlier slot's prd
         end
      end
   end

   // Commits of this cycle are folded in before a rollback copies the table
   always_comb
   begin
      arat_nxt = arat;
      for (int k = 0; k < COMMIT_WIDTH; k++)
      begin
         if (commit[k].we)
            arat_nxt[commit[k].lrd] = commit[k].prd;
      end
   end

   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         for (int i = 0; i < N_LRF; i++)
            arat[i] <= PRF_AW'(i);                // Identity mapping
      end
      else
      begin
         arat <= arat_nxt;
      end
   end

   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         for (int i = 0; i < N_LRF; i++)
            rat[i] <= PRF_AW'(i);
      end
      else if (rollback)
      begin
         rat <= arat_nxt;                         // The request group is dropped
      end
      else
      begin
         for (int i = 0; i < ISSUE_WIDTH; i++)
         begin
            if (slot_we[i])
               rat[req[i].lrd] <= fl_prd[i];      // Later slots overwrite earlier ones
         end
      end
   end

   always_comb
   begin
      commit_dup = 1'b0;
      for (int k = 1; k < COMMIT_WIDTH; k++)
      begin
         for (int m = 0; m < k; m++)
         begin
            if (commit[k].we && commit[m].we && commit[k].lrd == commit[m].lrd)
               commit_dup = 1'b1;
         end
      end
   end

   // The ROB retires at most one writer per logical register in a cycle
   a_commit_lrd_unique : assert property (
      @(posedge clk) disable iff (!rst_n) !commit_dup
   );

endmodule

//--- rename/rn_rename.sv
/*
   Rename stage top level, alias tables plus free list with registered responses
*/
module rn_rename
   import rn_pkg::*;
#(
   parameter int ISSUE_WIDTH  = 2,
   parameter int COMMIT_WIDTH = 2
)
(
   input  logic       clk,
   input  logic       rst_n,
   input  rn_req_t    req [ISSUE_WIDTH],
   input  logic       rollback,
   input  rn_commit_t commit [COMMIT_WIDTH],
   output rn_rsp_t    rsp [ISSUE_WIDTH],
   output logic       rename_ready
);

   logic [ISSUE_WIDTH-1:0] alloc;                 // Slots that need a new destination
   logic [PRF_AW-1:0]      fl_prd [ISSUE_WIDTH];
   logic [PRF_AW-1:0]      prs1 [ISSUE_WIDTH];
   logic [PRF_AW-1:0]      prs2 [ISSUE_WIDTH];
   logic [PRF_AW-1:0]      pfree [ISSUE_WIDTH];

   always_comb
   begin
      for (int i = 0; i < ISSUE_WIDTH; i++)
         alloc[i] = req[i].valid & req[i].lrd_we;
   end

   rn_rat #(
      .ISSUE_WIDTH  (ISSUE_WIDTH),
      .COMMIT_WIDTH (COMMIT_WIDTH)
   ) u_rat (
      .clk      (clk),
      .rst_n    (rst_n),
      .req      (req),
      .fl_prd   (fl_prd),
      .rollback (rollback),
      .commit   (commit),
      .prs1     (prs1),
      .prs2     (prs2),
      .pfree    (pfree)
   );

   rn_freelist #(
      .ISSUE_WIDTH  (ISSUE_WIDTH),
      .COMMIT_WIDTH (COMMIT_WIDTH)
   ) u_freelist (
      .clk          (clk),
      .rst_n        (rst_n),
      .alloc        (alloc),
      .rollback     (rollback),
      .commit       (commit),
      .fl_prd       (fl_prd),
      .rename_ready (rename_ready)
   );

   // Only the valid bits are reset; a rollback squashes the group in flight
   always_ff @(posedge clk)
   begin
      for (int i = 0; i < ISSUE_WIDTH; i++)
      begin
         rsp[i].prs1  <= prs1[i];
         rsp[i].prs2  <= prs2[i];
         rsp[i].prd   <= fl_prd[i];
         rsp[i].pfree <= pfree[i];
         if (!rst_n)
            rsp[i].valid <= 1'b0;
         else
            rsp[i].valid <= req[i].valid & ~rollback;
      end
   end

endmodule

//--- test/tb_rename.sv
/*
   Directed testbench for the rename stage, with a reference model of the
   alias tables and the free list
*/
module tb_rename
   import rn_pkg::*;
();
   timeunit 1ns;
   timeprecision 1ps;

   localparam int IW      = 2;
   localparam int CW      = 2;
   localparam int TIMEOUT = 20;

   logic       clk = 1'b0;
   logic       rst_n;
   rn_req_t    req [IW];
   logic       rollback;
   rn_commit_t commit [CW];
   rn_rsp_t    rsp [IW];
   logic       rename_ready;

   logic [PRF_AW-1:0] m_rat [N_LRF];
   logic [PRF_AW-1:0] m_arat [N_LRF];
   logic [PRF_AW-1:0] m_fl [$];                   // Committed head up to the tail
   int                m_spec;                     // Entries handed out, not yet committed
   rn_commit_t        rob_q [$];                  // Renamed writers, oldest first
   rn_rsp_t           exp_rsp [IW];
   logic [IW-1:0]     exp_we;
   int                errors = 0;

   rn_rename #(.ISSUE_WIDTH(IW), .COMMIT_WIDTH(CW)) dut0 (
      .clk          (clk),
      .rst_n        (rst_n),
      .req          (req),
      .rollback     (rollback),
      .commit       (commit),
      .rsp          (rsp),
      .rename_ready (rename_ready)
   );

   always #50 clk = ~clk;

   function automatic logic model_ready();
      return (m_fl.size() - m_spec) >= IW;
   endfunction

   function automatic logic rsp_seen();
      logic seen;
      seen = 1'b0;
      for (int i = 0; i < IW; i++)
         seen = seen | rsp[i].valid;
      return seen;
   endfunction

   task automatic reset_model();
      for (int i = 0; i < N_LRF; i++)
      begin
         m_rat[i]  = PRF_AW'(i);
         m_arat[i] = PRF_AW'(i);
      end
      m_fl.delete();
      for (int i = 0; i < FL_DEPTH; i++)
         m_fl.push_back(PRF_AW'(N_LRF + i));
      m_spec = 0;
      rob_q.delete();
   endtask

   task automatic clear_inputs();
      for (int i = 0; i < IW; i++)
         req[i] = '0;
      for (int k = 0; k < CW; k++)
         commit[k] = '0;
      rollback = 1'b0;
   endtask

   task automatic set_slot(input int i, input int we, input int s1, input int s2, input int d);
      req[i].valid  = 1'b1;
      req[i].lrd_we = (we != 0);
      req[i].lrs1   = LRF_AW'(s1);
      req[i].lrs2   = LRF_AW'(s2);
      req[i].lrd    = LRF_AW'(d);
   endtask

   // Retires the oldest writers but never two with the same lrd in one cycle
   task automatic commit_oldest(input int n);
      for (int k = 0; k < n && k < CW; k++)
      begin
         if (rob_q.size() > 0 && (k == 0 || rob_q[0].lrd != commit[0].lrd))
            commit[k] = rob_q.pop_front();
      end
   endtask

   task automatic compare_field(input string name, input int slot,
                                input logic [PRF_AW-1:0] got, input logic [PRF_AW-1:0] exp);
      if (got !== exp)
      begin
         $display("Fail rsp[%0d].%s: got %h, expected %h", slot, name, got, exp);
         errors++;
      end
   endtask

   // Runs the driven inputs through the model, clocks once and checks rsp
   task automatic step();
      rn_commit_t e;
      int         t;
      if (rename_ready !== model_ready())
      begin
         $display("Fail rename_ready: got %h, expected %h", rename_ready, model_ready());
         errors++;
      end
      for (int i = 0; i < IW; i++)
         exp_rsp[i] = '0;
      exp_we = '0;
      if (!rollback)
      begin
         for (int i = 0; i < IW; i++)
         begin
            exp_rsp[i].valid = req[i].valid;
            exp_rsp[i].prs1  = m_rat[req[i].lrs1];        // Earlier slots already wrote m_rat
            exp_rsp[i].prs2  = m_rat[req[i].lrs2];
            exp_rsp[i].pfree = m_rat[req[i].lrd];
            if (req[i].valid && req[i].lrd_we)
            begin
               exp_we[i]          = 1'b1;
               exp_rsp[i].prd     = m_fl[m_spec];
               m_spec++;
               m_rat[req[i].lrd] = exp_rsp[i].prd;
               e.we    = 1'b1;
               e.lrd   = req[i].lrd;
               e.prd   = exp_rsp[i].prd;
               e.pfree = exp_rsp[i].pfree;
               rob_q.push_back(e);
            end
         end
      end
      for (int k = 0; k < CW; k++)
      begin
         if (commit[k].we)
         begin
            m_arat[commit[k].lrd] = commit[k].prd;
            m_fl.push_back(commit[k].pfree);
            void'(m_fl.pop_front());                      // Committed head moves past its prd
            m_spec--;
         end
      end
      if (rollback)
      begin
         m_rat = m_arat;
         m_spec = 0;
         rob_q.delete();
      end
      @(posedge clk);
      #5;
      clear_inputs();
      t = 0;
      if (exp_rsp[0].valid || exp_rsp[IW-1].valid)
      begin
         while (!rsp_seen() && t < TIMEOUT)
         begin
            @(posedge clk);
            #5;
            t++;
         end
         if (!rsp_seen())
         begin
            $display("Timed out waiting for rsp valid");
            errors++;
         end
      end
      for (int i = 0; i < IW; i++)
      begin
         if (rsp[i].valid !== exp_rsp[i].valid)
         begin
            $display("Fail rsp[%0d].valid: got %h, expected %h", i, rsp[i].valid,
                     exp_rsp[i].valid);
            errors++;
         end
         else if (exp_rsp[i].valid)
         begin
            compare_field("prs1", i, rsp[i].prs1, exp_rsp[i].prs1);
            compare_field("prs2", i, rsp[i].prs2, exp_rsp[i].prs2);
            if (exp_we[i])
            begin
               compare_field("prd", i, rsp[i].prd, exp_rsp[i].prd);
               compare_field("pfree", i, rsp[i].pfree, exp_rsp[i].pfree);
            end
         end
      end
   endtask

   task automatic lookup_after_reset();
      set_slot(0, 0, 0, 1, 0);
      set_slot(1, 0, 2, 3, 0);
      step();
   endtask

   task automatic alloc_in_sequence();
      set_slot(0, 1, 4, 5, 1);
      set_slot(1, 1, 6, 7, 2);
      step();
      set_slot(0, 1, 1, 2, 3);
      set_slot(1, 1, 3, 1, 1);
      step();
      set_slot(0, 1, 3, 1, 2);
      set_slot(1, 1, 0, 0, 5);
      step();
   endtask

   task automatic group_hazards();
      set_slot(0, 1, 8, 9, 7);
      set_slot(1, 1, 7, 7, 7);                            // RAW and WAW on slot 0
      step();
      set_slot(1, 1, 7, 10, 11);                          // Slot 1 alone takes the next entry
      step();
   endtask

   task automatic rollback_to_commit();
      set_slot(0, 1, 1, 2, 12);
      set_slot(1, 1, 12, 3, 13);
      step();
      commit_oldest(2);
      step();
      commit_oldest(2);
      set_slot(0, 1, 1, 2, 3);
      rollback = 1'b1;                                    // This group is dropped
      step();
      set_slot(0, 0, 1, 2, 0);
      set_slot(1, 0, 3, 12, 0);
      step();
      set_slot(0, 1, 13, 5, 20);
      step();
   endtask

   task automatic drain_and_refill();
      int n;
      n = 0;
      while (model_ready() && n < 40)
      begin
         set_slot(0, 1, n, n + 1, n);
         set_slot(1, 1, n + 2, n, n + 7);
         step();
         n++;
      end
      if (rename_ready !== 1'b0)
      begin
         $display("rename_ready stayed high after the free list was drained");
         errors++;
      end
      commit_oldest(2);
      step();
      if (rename_ready !== 1'b1)
      begin
         $display("rename_ready did not rise after commits freed registers");
         errors++;
      end
      set_slot(0, 1, 4, 5, 6);
      set_slot(1, 1, 6, 7, 8);
      step();
      commit_oldest(2);                                   // Second freed pair queues behind the first
      step();
      set_slot(0, 1, 9, 10, 11);
      set_slot(1, 1, 11, 12, 13);
      step();
   endtask

   task automatic random_mix();
      for (int cyc = 0; cyc < 300; cyc++)
      begin
         if (model_ready())
         begin
            for (int i = 0; i < IW; i++)
            begin
               if ($urandom % 4 != 0)
                  set_slot(i, $urandom % 2, $urandom % N_LRF, $urandom % N_LRF,
                           $urandom % N_LRF);
            end
         end
         if ($urandom % 2 == 1)
            commit_oldest($urandom % 3);
         rollback = ($urandom % 16 == 0);
         step();
      end
   endtask

   initial
   begin
      void'($urandom(32'hdb0e1965));
      rst_n = 1'b0;
      clear_inputs();
      reset_model();
      repeat (10) @(posedge clk);
      #5;
      rst_n = 1'b1;
      if (rsp_seen() !== 1'b0 || rename_ready !== 1'b1)
      begin
         $display("Outputs after reset are not idle with rename_ready high");
         errors++;
      end
      lookup_after_reset();
      alloc_in_sequence();
      group_hazards();
      rollback_to_commit();
      drain_and_refill();
      random_mix();
      $display("Error count: %0d", errors);
      if (errors == 0)
         $display("No errors");
      else
         $display("Errors found");
      $finish;
   end

endmodule
